/* hw/vscpu_pkg.sv */
// VerySimpleCPU system package with word types, address map and FSM encodings
package vscpu_pkg;

    localparam int NUM_BANKS    = 2;        // Local memory banks
    localparam int BANK_WORDS   = 512;      // Words per bank
    localparam int BANK_OFF_W   = 9;        // Offset bits inside a bank
    localparam int BANK_SEL_W   = $clog2(NUM_BANKS);
    localparam int MAIN_WORDS   = 64;       // Main memory depth
    localparam int GPIO_IN_OFF  = 62;       // Main memory word that reads the input pins
    localparam int GPIO_OUT_OFF = 63;       // Main memory word that drives the output pins
    localparam int SHIFT_LIMIT  = 32;       // SRL turns into a left shift from here on

    typedef logic [31:0]           word_t;       // Data or instruction word
    typedef logic [13:0]           addr_t;       // Core word address
    typedef logic [BANK_OFF_W-1:0] bank_addr_t;  // Offset inside one bank
    typedef logic [5:0]            main_addr_t;  // Offset inside main memory
    typedef logic [10:0]           gpio_t;       // GPIO pins

    localparam addr_t MAIN_BASE = 14'h2000;  // First main memory word
    localparam addr_t DONE_ADDR = 14'h3FFF;  // A write here ends the run

    // Opcode field, standard VerySimpleCPU encoding
    typedef enum logic [2:0] {
        ADD  = 3'd0,
        NAND = 3'd1,
        SRL  = 3'd2,
        LT   = 3'd3,
        CP   = 3'd5,
        CPI  = 3'd6,
        BZJ  = 3'd4,
        MUL  = 3'd7
    } opcode_t;

    typedef enum logic [3:0] {
        IDLE,
        FETCH,
        DECODE,
        READ_A,     // mem[A], or the pointer for CPIi
        READ_B,     // mem[B]
        READ_IND,   // Second hop of plain CPI
        EXEC,
        WRITE,
        HALT        // One cycle after the done write
    } core_state_t;

endpackage

/* hw/local_sram.sv */
// Local memory bank, 512 words with a registered single-port read
`timescale 1ns/1ps
`default_nettype none

module local_sram (
    input  logic                  clk_i,
    input  logic                  en_i,       // Access this cycle
    input  logic                  we_i,
    input  vscpu_pkg::bank_addr_t addr_i,
    input  vscpu_pkg::word_t      wdata_i,
    output vscpu_pkg::word_t      rdata_o
);

    vscpu_pkg::word_t mem [vscpu_pkg::BANK_WORDS];

    // Read returns the old word on a write, like the macro
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i)
                mem[addr_i] <= wdata_i;
            rdata_o <= mem[addr_i];
        end
    end

endmodule

`default_nettype wire

/* hw/main_memory.sv */
// Main memory, 64 words with the top two words mapped to the GPIO pins
`timescale 1ns/1ps
`default_nettype none

module main_memory (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  we_i,
    input  vscpu_pkg::main_addr_t addr_i,
    input  vscpu_pkg::word_t      wdata_i,
    output vscpu_pkg::word_t      rdata_o,
    input  vscpu_pkg::gpio_t      gpio_i,
    output vscpu_pkg::gpio_t      gpio_o
);

    vscpu_pkg::word_t mem [vscpu_pkg::MAIN_WORDS];

    always_ff @(posedge clk_i) begin
        if (we_i)
            mem[addr_i] <= wdata_i;
        if (addr_i == vscpu_pkg::GPIO_IN_OFF)
            rdata_o <= vscpu_pkg::word_t'(gpio_i);   // Pins, zero-extended
        else
            rdata_o <= mem[addr_i];
    end

    // Output pins follow the last write to the output word
    always_ff @(posedge clk_i) begin
        if (rst_i)
            gpio_o <= '0;
        else if (we_i && addr_i == vscpu_pkg::GPIO_OUT_OFF)
            gpio_o <= vscpu_pkg::gpio_t'(wdata_i);
    end

endmodule

`default_nettype wire

/* hw/vscpu_core.sv */
// VerySimpleCPU core, multi-cycle fetch, operand read, execute and write-back FSM
`timescale 1ns/1ps
`default_nettype none

module vscpu_core (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             run_i,        // High while the controller lets the core run
    output logic             mem_req_o,    // One-cycle request strobe
    output logic             mem_we_o,
    output vscpu_pkg::addr_t mem_addr_o,
    output vscpu_pkg::word_t mem_wdata_o,
    input  logic             mem_vld_i,    // Answer, one cycle after the request
    input  vscpu_pkg::word_t mem_rdata_i
);

    vscpu_pkg::core_state_t state_q;
    vscpu_pkg::core_state_t state_d;
    logic                   wait_q;   // Request out, answer pending
    vscpu_pkg::addr_t       pc_q;
    vscpu_pkg::word_t       ir_q;
    vscpu_pkg::word_t       a_q;      // mem[A]
    vscpu_pkg::word_t       b_q;      // mem[B], or mem[mem[B]] after the indirect read
    vscpu_pkg::word_t       res_q;
    vscpu_pkg::addr_t       dst_q;

    vscpu_pkg::opcode_t     op;
    logic                   imm;
    vscpu_pkg::addr_t       a_fld;
    vscpu_pkg::addr_t       b_fld;
    vscpu_pkg::word_t       b_imm;
    vscpu_pkg::word_t       op2;
    vscpu_pkg::word_t       result;

    // Instruction fields
    assign op    = vscpu_pkg::opcode_t'(ir_q[31:29]);
    assign imm   = ir_q[28];
    assign a_fld = ir_q[27:14];
    assign b_fld = ir_q[13:0];
    assign b_imm = vscpu_pkg::word_t'(b_fld);   // Zero-extended
    assign op2   = imm ? b_imm : b_q;           // Second operand

    // ALU
    always_comb begin
        case (op)
            vscpu_pkg::ADD:  result = a_q + op2;
            vscpu_pkg::NAND: result = ~(a_q & op2);
            vscpu_pkg::SRL: begin
                if (op2 < vscpu_pkg::SHIFT_LIMIT)
                    result = a_q >> op2;
                else
                    result = a_q << (op2 - vscpu_pkg::SHIFT_LIMIT);
            end
            vscpu_pkg::LT:   result = (a_q < op2) ? 32'd1 : 32'd0;
            vscpu_pkg::CP:   result = op2;                // CPi stores B itself
            vscpu_pkg::MUL:  result = a_q * op2;          // Low 32 bits only
            default:         result = b_q;                // Both CPI forms copy b_q
        endcase
    end

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            vscpu_pkg::IDLE:  if (run_i) state_d = vscpu_pkg::FETCH;
            vscpu_pkg::FETCH: if (mem_vld_i) state_d = vscpu_pkg::DECODE;
            vscpu_pkg::DECODE: begin
                if (op == vscpu_pkg::CP && imm)
                    state_d = vscpu_pkg::EXEC;           // Nothing to read
                else if (op == vscpu_pkg::CP || (op == vscpu_pkg::CPI && !imm))
                    state_d = vscpu_pkg::READ_B;         // mem[A] not needed
                else
                    state_d = vscpu_pkg::READ_A;
            end
            vscpu_pkg::READ_A: begin
                if (mem_vld_i)
                    state_d = (imm && op != vscpu_pkg::CPI) ? vscpu_pkg::EXEC
                                                            : vscpu_pkg::READ_B;
            end
            vscpu_pkg::READ_B: begin
                if (mem_vld_i)
                    state_d = (op == vscpu_pkg::CPI && !imm) ? vscpu_pkg::READ_IND
                                                             : vscpu_pkg::EXEC;
            end
            vscpu_pkg::READ_IND: if (mem_vld_i) state_d = vscpu_pkg::EXEC;
            vscpu_pkg::EXEC: begin
                state_d = (op == vscpu_pkg::BZJ) ? vscpu_pkg::FETCH : vscpu_pkg::WRITE;
            end
            vscpu_pkg::WRITE: begin
                if (mem_vld_i)
                    state_d = (dst_q == vscpu_pkg::DONE_ADDR) ? vscpu_pkg::HALT
                                                              : vscpu_pkg::FETCH;
            end
            default: state_d = vscpu_pkg::IDLE;
        endcase
        // Run dropped by the controller
        if (!run_i && state_d != vscpu_pkg::HALT)
            state_d = vscpu_pkg::IDLE;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= vscpu_pkg::IDLE;
            wait_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (mem_req_o)
                wait_q <= 1'b1;
            else if (mem_vld_i)
                wait_q <= 1'b0;
        end
    end

    // Datapath registers
    always_ff @(posedge clk_i) begin
        if (state_q == vscpu_pkg::IDLE)
            pc_q <= '0;                                   // Every run starts at 0
        if (mem_vld_i) begin
            case (state_q)
                vscpu_pkg::FETCH:    ir_q <= mem_rdata_i;
                vscpu_pkg::READ_A:   a_q  <= mem_rdata_i;
                vscpu_pkg::READ_B:   b_q  <= mem_rdata_i;
                vscpu_pkg::READ_IND: b_q  <= mem_rdata_i;
                vscpu_pkg::WRITE:    pc_q <= pc_q + 1'b1;
                default: ;
            endcase
        end
        if (state_q == vscpu_pkg::EXEC) begin
            res_q <= result;
            // CPIi stores through the pointer held at A
            dst_q <= (op == vscpu_pkg::CPI && imm) ? vscpu_pkg::addr_t'(a_q) : a_fld;
            if (op == vscpu_pkg::BZJ) begin
                if (imm)
                    pc_q <= vscpu_pkg::addr_t'(a_q + b_imm);
                else if (b_q == '0)
                    pc_q <= vscpu_pkg::addr_t'(a_q);
                else
                    pc_q <= pc_q + 1'b1;
            end
        end
    end

    // Memory request
    assign mem_req_o   = !wait_q && (state_q inside {vscpu_pkg::FETCH, vscpu_pkg::READ_A,
                         vscpu_pkg::READ_B, vscpu_pkg::READ_IND, vscpu_pkg::WRITE});
    assign mem_we_o    = (state_q == vscpu_pkg::WRITE);
    assign mem_wdata_o = res_q;

    always_comb begin
        case (state_q)
            vscpu_pkg::READ_A:   mem_addr_o = a_fld;
            vscpu_pkg::READ_B:   mem_addr_o = b_fld;
            vscpu_pkg::READ_IND: mem_addr_o = vscpu_pkg::addr_t'(b_q);   // Pointer from mem[B]
            vscpu_pkg::WRITE:    mem_addr_o = dst_q;
            default:             mem_addr_o = pc_q;
        endcase
    end

endmodule

`default_nettype wire

/* hw/mem_controller.sv */
// Memory controller, routes core or host requests by address and keeps run and done
`timescale 1ns/1ps
`default_nettype none

module mem_controller (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            start_i,
    input  logic                            host_we_i,     // Ignored while running
    input  vscpu_pkg::addr_t                host_addr_i,
    input  vscpu_pkg::word_t                host_wdata_i,
    output vscpu_pkg::word_t                host_rdata_o,
    output logic                            done_o,
    output logic                            run_o,
    input  logic                            mem_req_i,     // Core side
    input  logic                            mem_we_i,
    input  vscpu_pkg::addr_t                mem_addr_i,
    input  vscpu_pkg::word_t                mem_wdata_i,
    output logic                            mem_vld_o,
    output vscpu_pkg::word_t                mem_rdata_o,
    output logic [vscpu_pkg::NUM_BANKS-1:0] bank_en_o,
    output logic [vscpu_pkg::NUM_BANKS-1:0] bank_we_o,
    output vscpu_pkg::bank_addr_t           bank_addr_o,
    output vscpu_pkg::word_t                bank_wdata_o,
    input  vscpu_pkg::word_t                bank_rdata_i [vscpu_pkg::NUM_BANKS],
    output logic                            main_we_o,
    output vscpu_pkg::main_addr_t           main_addr_o,
    output vscpu_pkg::word_t                main_wdata_o,
    input  vscpu_pkg::word_t                main_rdata_i
);

    logic                              run_q;
    logic                              done_q;
    logic                              vld_q;
    logic                              req;
    logic                              we;
    vscpu_pkg::addr_t                  addr;
    vscpu_pkg::word_t                  wdata;
    logic                              in_bank;
    logic                              in_main;
    logic                              in_done;
    logic [vscpu_pkg::BANK_SEL_W-1:0]  bank_idx;
    logic [vscpu_pkg::BANK_SEL_W-1:0]  bank_idx_q;
    logic                              sel_bank_q;
    logic                              sel_main_q;
    logic                              sel_done_q;
    vscpu_pkg::word_t                  rdata;

    // Requester mux, host reads every cycle while idle
    assign req   = run_q ? mem_req_i : 1'b1;
    assign we    = run_q ? (mem_req_i & mem_we_i) : host_we_i;
    assign addr  = run_q ? mem_addr_i : host_addr_i;
    assign wdata = run_q ? mem_wdata_i : host_wdata_i;

    // Region decode
    assign in_bank  = addr < vscpu_pkg::NUM_BANKS * vscpu_pkg::BANK_WORDS;
    assign in_main  = addr >= vscpu_pkg::MAIN_BASE &&
                      addr < vscpu_pkg::MAIN_BASE + vscpu_pkg::MAIN_WORDS;
    assign in_done  = (addr == vscpu_pkg::DONE_ADDR);
    assign bank_idx = addr[vscpu_pkg::BANK_OFF_W +: vscpu_pkg::BANK_SEL_W];

    always_comb begin
        for (int i = 0; i < vscpu_pkg::NUM_BANKS; i++) begin
            bank_en_o[i] = req && in_bank && (bank_idx == i);
            bank_we_o[i] = we && in_bank && (bank_idx == i);
        end
    end

    assign bank_addr_o  = vscpu_pkg::bank_addr_t'(addr);   // Shared by all banks
    assign bank_wdata_o = wdata;
    assign main_we_o    = we && in_main;
    assign main_addr_o  = vscpu_pkg::main_addr_t'(addr);
    assign main_wdata_o = wdata;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            run_q  <= 1'b0;
            done_q <= 1'b0;
            vld_q  <= 1'b0;
        end else begin
            vld_q <= run_q && mem_req_i;                     // Every region answers in one cycle
            if (start_i && !run_q) begin
                run_q  <= 1'b1;
                done_q <= 1'b0;
            end else if (run_q && mem_req_i && mem_we_i && in_done) begin
                run_q  <= 1'b0;                              // Core halts itself
                done_q <= 1'b1;
            end
        end
    end

    // Region of the access in flight, steers the read data back
    always_ff @(posedge clk_i) begin
        sel_bank_q <= in_bank;
        sel_main_q <= in_main;
        sel_done_q <= in_done;
        bank_idx_q <= bank_idx;
    end

    always_comb begin
        if (sel_bank_q)
            rdata = bank_rdata_i[bank_idx_q];
        else if (sel_main_q)
            rdata = main_rdata_i;
        else if (sel_done_q)
            rdata = vscpu_pkg::word_t'(done_q);
        else
            rdata = '0;   // Unmapped
    end

    assign mem_rdata_o  = rdata;
    assign mem_vld_o    = vld_q;
    assign host_rdata_o = rdata;
    assign done_o       = done_q;
    assign run_o        = run_q | start_i;   // Lets the core leave IDLE on the start edge

endmodule

`default_nettype wire

/* hw/vscpu_system.sv */
// VerySimpleCPU system top with core, memory controller, local banks and main memory
`timescale 1ns/1ps
`default_nettype none

module vscpu_system (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             start_i,
    input  logic             host_we_i,
    input  vscpu_pkg::addr_t host_addr_i,
    input  vscpu_pkg::word_t host_wdata_i,
    output vscpu_pkg::word_t host_rdata_o,
    input  vscpu_pkg::gpio_t gpio_i,
    output vscpu_pkg::gpio_t gpio_o,
    output logic             done_o
);

    logic                            run;
    logic                            mem_req;
    logic                            mem_we;
    logic                            mem_vld;
    vscpu_pkg::addr_t                mem_addr;
    vscpu_pkg::word_t                mem_wdata;
    vscpu_pkg::word_t                mem_rdata;
    logic [vscpu_pkg::NUM_BANKS-1:0] bank_en;
    logic [vscpu_pkg::NUM_BANKS-1:0] bank_we;
    vscpu_pkg::bank_addr_t           bank_addr;    // Shared by all banks
    vscpu_pkg::word_t                bank_wdata;
    vscpu_pkg::word_t                bank_rdata [vscpu_pkg::NUM_BANKS];
    logic                            main_we;
    vscpu_pkg::main_addr_t           main_addr;
    vscpu_pkg::word_t                main_wdata;
    vscpu_pkg::word_t                main_rdata;

    vscpu_core inst_core (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .run_i(run),
        .mem_req_o(mem_req),
        .mem_we_o(mem_we),
        .mem_addr_o(mem_addr),
        .mem_wdata_o(mem_wdata),
        .mem_vld_i(mem_vld),
        .mem_rdata_i(mem_rdata)
    );

    mem_controller inst_main_controller (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .start_i(start_i),
        .host_we_i(host_we_i),
        .host_addr_i(host_addr_i),
        .host_wdata_i(host_wdata_i),
        .host_rdata_o(host_rdata_o),
        .done_o(done_o),
        .run_o(run),
        .mem_req_i(mem_req),
        .mem_we_i(mem_we),
        .mem_addr_i(mem_addr),
        .mem_wdata_i(mem_wdata),
        .mem_vld_o(mem_vld),
        .mem_rdata_o(mem_rdata),
        .bank_en_o(bank_en),
        .bank_we_o(bank_we),
        .bank_addr_o(bank_addr),
        .bank_wdata_o(bank_wdata),
        .bank_rdata_i(bank_rdata),
        .main_we_o(main_we),
        .main_addr_o(main_addr),
        .main_wdata_o(main_wdata),
        .main_rdata_i(main_rdata)
    );

    // Local memory banks
    for (genvar i = 0; i < vscpu_pkg::NUM_BANKS; i++) begin : g_bank
        local_sram inst_sram (
            .clk_i(clk_i),
            .en_i(bank_en[i]),
            .we_i(bank_we[i]),
            .addr_i(bank_addr),
            .wdata_i(bank_wdata),
            .rdata_o(bank_rdata[i])
        );
    end

    main_memory inst_main_memory (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .we_i(main_we),
        .addr_i(main_addr),
        .wdata_i(main_wdata),
        .rdata_o(main_rdata),
        .gpio_i(gpio_i),
        .gpio_o(gpio_o)
    );

endmodule

`default_nettype wire

/* bench/tb_vscpu_system.sv */
// Testbench for the VerySimpleCPU system, loads and runs programs and checks the results
`timescale 1ns/1ps
`default_nettype none

module tb_vscpu_system;

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DLY    = 2;        // Inputs change this long after the rising edge
    localparam int RESET_CYCLES = 8;
    localparam int RUN_CYCLES   = 20000;    // Watchdog share per program run
    localparam int BUSY_WAIT    = 4;        // Cycles into a run before the stray host write

    logic                  clk_i;
    logic                  rst_i;
    logic                  start_i;
    logic                  host_we_i;
    vscpu_pkg::addr_t      host_addr_i;
    vscpu_pkg::word_t      host_wdata_i;
    vscpu_pkg::word_t      host_rdata_o;
    vscpu_pkg::gpio_t      gpio_i;
    vscpu_pkg::gpio_t      gpio_o;
    logic                  done_o;

    logic [63:0]           rec_kind [$];    // Keyword of each record
    vscpu_pkg::word_t      rec_arg0 [$];    // Address or pin value
    vscpu_pkg::word_t      rec_arg1 [$];    // Data word
    int                    errors;
    int                    num_runs;        // start and busy records
    logic                  limit_set;
    logic                  ran_before;      // A run has ended, so done_o must hold

    vscpu_system uut (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .start_i(start_i),
        .host_we_i(host_we_i),
        .host_addr_i(host_addr_i),
        .host_wdata_i(host_wdata_i),
        .host_rdata_o(host_rdata_o),
        .gpio_i(gpio_i),
        .gpio_o(gpio_o),
        .done_o(done_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Whole file into the record queues, comment lines start with a lone #
    task automatic read_patterns();
        int               fd;
        int               rc;
        logic [63:0]      tok;
        logic [8*160-1:0] rest;
        vscpu_pkg::word_t v0;
        vscpu_pkg::word_t v1;
        fd = $fopen("bench/vscpu_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the patterns file");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            tok = '0;
            v0  = '0;
            v1  = '0;
            rc  = $fscanf(fd, "%s", tok);
            if (rc != 1)
                break;
            if (tok == "#") begin
                rc = $fgets(rest, fd);       // Rest of the comment line
                continue;
            end
            if (tok == "load" || tok == "expect" || tok == "busy")
                rc = $fscanf(fd, "%h %h", v0, v1);
            else if (tok == "gpio" || tok == "pins")
                rc = $fscanf(fd, "%h", v0);
            else if (tok != "start" && tok != "end") begin
                $display("Unknown record kind in the patterns file");
                errors++;
                continue;
            end
            if (tok == "start" || tok == "busy")
                num_runs++;
            rec_kind.push_back(tok);
            rec_arg0.push_back(v0);
            rec_arg1.push_back(v1);
        end
        $fclose(fd);
    endtask

    // Host write lands on the next edge unless the core runs
    task automatic host_write(input vscpu_pkg::addr_t addr, input vscpu_pkg::word_t data);
        host_addr_i  = addr;
        host_wdata_i = data;
        host_we_i    = 1'b1;
        @(posedge clk_i);
        #DRIVE_DLY;
        host_we_i    = 1'b0;
    endtask

    task automatic host_read(input vscpu_pkg::addr_t addr, output vscpu_pkg::word_t data);
        host_addr_i = addr;
        host_we_i   = 1'b0;
        @(posedge clk_i);
        #DRIVE_DLY;
        data = host_rdata_o;              // Registered read, one edge later
    endtask

    // Start pulse, optional stray host write mid-run, then wait for done_o
    task automatic run_program(input logic stray_write, input vscpu_pkg::addr_t addr,
                               input vscpu_pkg::word_t data);
        if (ran_before && !done_o) begin
            $display("done_o fell before the next start");
            errors++;
        end
        start_i = 1'b1;
        @(posedge clk_i);
        #DRIVE_DLY;
        start_i = 1'b0;
        if (done_o) begin
            $display("done_o still high after start");
            errors++;
        end
        if (stray_write) begin
            repeat (BUSY_WAIT) @(posedge clk_i);
            #DRIVE_DLY;
            host_write(addr, data);       // Must be ignored while running
        end
        while (!done_o) begin
            @(posedge clk_i);
            #DRIVE_DLY;
        end
        ran_before = 1'b1;
    endtask

    task automatic check_word(input vscpu_pkg::addr_t addr, input vscpu_pkg::word_t got,
                              input vscpu_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAIL host_rdata_o at %h: got %h, expected %h", addr, got, exp);
            errors++;
        end
    endtask

    task automatic check_gpio(input vscpu_pkg::gpio_t got, input vscpu_pkg::gpio_t exp);
        if (got !== exp) begin
            $display("FAIL gpio_o: got %h, expected %h", got, exp);
            errors++;
        end
    endtask

    // Budget grows with the number of runs, one extra share for host traffic
    initial begin : watchdog
        wait (limit_set);
        repeat (RUN_CYCLES * (num_runs + 1)) @(posedge clk_i);
        $display("Timeout, the programs did not finish in %0d cycles",
                 RUN_CYCLES * (num_runs + 1));
        $display("Errors: %0d", errors + 1);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        vscpu_pkg::word_t got;
        int               idx;
        clk_i        = 1'b0;
        rst_i        = 1'b1;
        start_i      = 1'b0;
        host_we_i    = 1'b0;
        host_addr_i  = '0;
        host_wdata_i = '0;
        gpio_i       = '0;
        errors       = 0;
        num_runs     = 0;
        limit_set    = 1'b0;
        ran_before   = 1'b0;
        read_patterns();
        limit_set = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DLY;
        rst_i = 1'b0;
        idx   = 0;
        while (idx < rec_kind.size() && rec_kind[idx] != "end") begin
            case (rec_kind[idx])
                "load":  host_write(vscpu_pkg::addr_t'(rec_arg0[idx]), rec_arg1[idx]);
                "gpio":  gpio_i = vscpu_pkg::gpio_t'(rec_arg0[idx]);
                "start": run_program(1'b0, '0, '0);
                "busy":  run_program(1'b1, vscpu_pkg::addr_t'(rec_arg0[idx]), rec_arg1[idx]);
                "expect": begin
                    host_read(vscpu_pkg::addr_t'(rec_arg0[idx]), got);
                    check_word(vscpu_pkg::addr_t'(rec_arg0[idx]), got, rec_arg1[idx]);
                end
                "pins":  check_gpio(gpio_o, vscpu_pkg::gpio_t'(rec_arg0[idx]));
                default: ;
            endcase
            idx++;
        end
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/vscpu_patterns.txt */
# Columns: kind, then address and word in hex for load, expect and busy, or pins in hex
# Kinds: load, gpio, start, busy (start with a host write while running), expect, pins, end
pins 000
# Arithmetic and copy program, plain ops then immediate ops on the same cells
load 0000 00400110
load 0001 20404110
load 0002 40408110
load 0003 6040c110
load 0004 e0410110
load 0005 10403fff
load 0006 304040ff
load 0007 50408025
load 0008 70425000
load 0009 f0410100
load 000a a0414100
load 000b b0419abc
load 000c c041c200
load 000d d0808101
load 000e bfffc001
load 0100 12345678
load 0101 f0f0f0f0
load 0102 80000000
load 0103 00000005
load 0104 00010001
load 0109 00000007
load 0110 00000014
load 0200 00000201
load 0201 deadbeef
load 0202 00000108
start
expect 0100 1234968b
expect 0101 ffffff10
expect 0102 00010000
expect 0103 00000001
expect 0104 14001400
expect 0105 1234968b
expect 0106 00001abc
expect 0107 deadbeef
expect 0108 ffffff10
expect 0109 00000001
# Branch program, sums 1 to 10 and skips a poisoned store while the host hits 0140
load 0000 004c0131
load 0001 004c4132
load 0002 804cc131
load 0003 804d0134
load 0004 904cc002
load 0005 b04d4bad
load 0006 b04daace
load 0007 bfffc001
load 0130 00000000
load 0131 0000000a
load 0132 ffffffff
load 0133 00000004
load 0134 00000000
load 0135 11111111
load 0140 00000077
busy 0140 0badf00d
expect 0130 00000037
expect 0131 00000000
expect 0135 11111111
expect 0136 00002ace
expect 0140 00000077
load 0140 0badf00d
expect 0140 0badf00d
# GPIO program, copies the input word to the output word
gpio 5a5
load 0000 a80fe03e
load 0001 bfffc001
start
pins 5a5
expect 203f 000005a5
end

/* files.f */
hw/vscpu_pkg.sv
hw/local_sram.sv
hw/main_memory.sv
hw/vscpu_core.sv
hw/mem_controller.sv
hw/vscpu_system.sv
bench/tb_vscpu_system.sv
